/* common/ex_pkg.sv */
//****************************************
// shared types of the RV64I execute stage.
// opcode values follow the RV64I base encoding, other opcodes are illegal.
// alu_op_e values 0 to 7 match funct3 so decode can cast them directly.
//****************************************

package ex_pkg;

	localparam int xlen   = 64; // data and address width.
	localparam int ilen   = 32; // instruction width.
	localparam int strb_w = 8;  // one strobe bit per data byte.

	// major opcodes, instr[6:0].
	typedef enum logic [6:0] {
		load      = 7'b0000011,
		op_imm    = 7'b0010011,
		auipc     = 7'b0010111,
		op_imm_32 = 7'b0011011,
		store     = 7'b0100011,
		op        = 7'b0110011,
		lui       = 7'b0110111,
		op_32     = 7'b0111011,
		system    = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sl   = 4'd1,
		alu_slt  = 4'd2,
		alu_sltu = 4'd3,
		alu_xor  = 4'd4,
		alu_sr   = 4'd5,
		alu_or   = 4'd6,
		alu_and  = 4'd7,
		alu_pass = 4'd8 // result is operand 1.
	} alu_op_e;

	// access size, taken from funct3[1:0] of loads and stores.
	typedef enum logic [1:0] {
		mem_byte   = 2'd0,
		mem_half   = 2'd1,
		mem_word   = 2'd2,
		mem_double = 2'd3
	} mem_size_e;

	typedef enum logic [1:0] {
		exc_none      = 2'd0,
		exc_mem_align = 2'd1,
		exc_illegal   = 2'd2
	} except_e;

	localparam logic [strb_w-1:0] strb_byte = 8'h01;
	localparam logic [strb_w-1:0] strb_half = 8'h03;
	localparam logic [strb_w-1:0] strb_word = 8'h0f;
	localparam logic [strb_w-1:0] strb_all  = 8'hff;

	typedef struct packed {
		alu_op_e         alu_op;
		logic            word;     // 32-bit form, result sign-extended from bit 31.
		logic            sub;
		logic            arith;    // arithmetic right shift.
		logic            op1_pc;
		logic            op2_imm;
		logic            op1_zero;
		logic            is_load;
		logic            is_store;
		mem_size_e       mem_size;
		logic            illegal;
		logic [xlen-1:0] imm;
	} ex_ctrl_t;

	typedef struct packed {
		logic              rd_en;
		logic              wr_en;
		logic [xlen-1:0]   addr;
		logic [xlen-1:0]   wr_data;
		logic [strb_w-1:0] wr_strb;
	} mem_req_t;

	typedef struct packed {
		logic [xlen-1:0] result;
		mem_req_t        mem;
		except_e         except;
	} ex_out_t;

endpackage

/* design/ex_ctrl.sv */
//****************************************
// instruction decode of the execute stage, purely combinational.
// only the opcode is checked for legality, funct fields are trusted.
//****************************************

`timescale 1ns/10ps

module ex_ctrl (
	input  logic [ex_pkg::ilen-1:0] instr,
	output ex_pkg::ex_ctrl_t        ctrl
);

	import ex_pkg::*;

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic            alt;   // funct7 bit 5, selects sub and sra.
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_u;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign alt    = instr[30];

	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'd0};

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = alu_add;
		case (opcode)
			op: begin
				ctrl.alu_op = alu_op_e'({1'b0, funct3});
				ctrl.sub    = alt;
				ctrl.arith  = alt;
			end
			op_imm: begin
				// no subi exists, so bit 30 only matters for srai.
				ctrl.alu_op  = alu_op_e'({1'b0, funct3});
				ctrl.arith   = alt;
				ctrl.op2_imm = 1'b1;
				ctrl.imm     = imm_i;
			end
			op_32: begin
				ctrl.alu_op = alu_op_e'({1'b0, funct3});
				ctrl.word   = 1'b1;
				ctrl.sub    = alt;
				ctrl.arith  = alt;
			end
			op_imm_32: begin
				ctrl.alu_op  = alu_op_e'({1'b0, funct3});
				ctrl.word    = 1'b1;
				ctrl.arith   = alt;
				ctrl.op2_imm = 1'b1;
				ctrl.imm     = imm_i;
			end
			lui: begin
				ctrl.op1_zero = 1'b1; // 0 + imm gives the upper immediate.
				ctrl.op2_imm  = 1'b1;
				ctrl.imm      = imm_u;
			end
			auipc: begin
				ctrl.op1_pc  = 1'b1;
				ctrl.op2_imm = 1'b1;
				ctrl.imm     = imm_u;
			end
			load: begin
				ctrl.op2_imm  = 1'b1;
				ctrl.imm      = imm_i;
				ctrl.is_load  = 1'b1;
				ctrl.mem_size = mem_size_e'(funct3[1:0]);
			end
			store: begin
				ctrl.op2_imm  = 1'b1;
				ctrl.imm      = imm_s;
				ctrl.is_store = 1'b1;
				ctrl.mem_size = mem_size_e'(funct3[1:0]);
			end
			system: begin
				ctrl.alu_op = alu_pass; // rs1 goes straight through.
			end
			default: begin
				// unknown opcode. The bundle stays an add with no memory access.
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

/* alu/ex_alu.sv */
//****************************************
// 64-bit RV64I integer ALU with operand selection.
// word forms use a 5-bit shift amount and sign-extend from bit 31.
// alu_op values outside the enum give a zero result.
//****************************************

`timescale 1ns/10ps

module ex_alu (
	input  ex_pkg::ex_ctrl_t        ctrl,
	input  logic [ex_pkg::xlen-1:0] pc,
	input  logic [ex_pkg::xlen-1:0] rs1_data,
	input  logic [ex_pkg::xlen-1:0] rs2_data,
	output logic [ex_pkg::xlen-1:0] result
);

	import ex_pkg::*;

	logic [xlen-1:0] op1;
	logic [xlen-1:0] op2;
	logic [5:0]      shamt;
	logic [xlen-1:0] sr_src;
	logic [xlen-1:0] add_res;
	logic [xlen-1:0] sl_res;
	logic [xlen-1:0] srl_res;
	logic [xlen-1:0] sra_res;
	logic            lt_s;
	logic            lt_u;
	logic [xlen-1:0] raw;

	function automatic logic [xlen-1:0] sext_word(input logic [31:0] val);
		return {{32{val[31]}}, val};
	endfunction

	always_comb begin
		if (ctrl.op1_zero)
			op1 = '0;
		else if (ctrl.op1_pc)
			op1 = pc;
		else
			op1 = rs1_data;
	end

	assign op2 = ctrl.op2_imm ? ctrl.imm : rs2_data;

	// bit 5 of the amount is ignored in word form.
	assign shamt = ctrl.word ? {1'b0, op2[4:0]} : op2[5:0];

	// right shifts in word form work on the low word, extended by shift kind.
	always_comb begin
		if (!ctrl.word)
			sr_src = op1;
		else if (ctrl.arith)
			sr_src = sext_word(op1[31:0]);
		else
			sr_src = {32'd0, op1[31:0]};
	end

	assign add_res = ctrl.sub ? op1 - op2 : op1 + op2;
	assign sl_res  = op1 << shamt;
	assign srl_res = sr_src >> shamt;
	assign sra_res = $signed(sr_src) >>> shamt;

	assign lt_s = $signed(op1) < $signed(op2);
	assign lt_u = op1 < op2;

	always_comb begin
		case (ctrl.alu_op)
			alu_add:  raw = add_res;
			alu_sl:   raw = sl_res;
			alu_slt:  raw = {{(xlen-1){1'b0}}, lt_s};
			alu_sltu: raw = {{(xlen-1){1'b0}}, lt_u};
			alu_xor:  raw = op1 ^ op2;
			alu_sr:   raw = ctrl.arith ? sra_res : srl_res;
			alu_or:   raw = op1 | op2;
			alu_and:  raw = op1 & op2;
			alu_pass: raw = op1;
			default:  raw = '0;
		endcase
	end

	// every word-form result is sign-extended from bit 31.
	assign result = ctrl.word ? sext_word(raw[31:0]) : raw;

endmodule

/* design/ex_mem_access.sv */
//****************************************
// load/store request formatting and the exception cause.
// any access with addr[2:0] nonzero is misaligned, whatever its size.
// store data is right-aligned, the strobe covers the low bytes.
//****************************************

`timescale 1ns/10ps

module ex_mem_access (
	input  ex_pkg::ex_ctrl_t        ctrl,
	input  logic [ex_pkg::xlen-1:0] addr,
	input  logic [ex_pkg::xlen-1:0] rs2_data,
	output ex_pkg::mem_req_t        req,
	output ex_pkg::except_e         except
);

	import ex_pkg::*;

	logic access;
	logic misaligned;

	assign access     = ctrl.is_load | ctrl.is_store;
	assign misaligned = access && (addr[2:0] != 3'd0);

	always_comb begin
		req = '0;
		if (ctrl.is_load) begin
			req.rd_en = 1'b1;
			req.addr  = addr;
		end
		if (ctrl.is_store) begin
			req.wr_en = 1'b1;
			req.addr  = addr;
			case (ctrl.mem_size)
				mem_byte: begin
					req.wr_data = {56'd0, rs2_data[7:0]};
					req.wr_strb = strb_byte;
				end
				mem_half: begin
					req.wr_data = {48'd0, rs2_data[15:0]};
					req.wr_strb = strb_half;
				end
				mem_word: begin
					req.wr_data = {32'd0, rs2_data[31:0]};
					req.wr_strb = strb_word;
				end
				default: begin
					req.wr_data = rs2_data;
					req.wr_strb = strb_all;
				end
			endcase
		end
	end

	// the request is still shown on a misaligned access.
	always_comb begin
		if (misaligned)
			except = exc_mem_align;
		else if (ctrl.illegal)
			except = exc_illegal; // decided once in ex_ctrl.
		else
			except = exc_none;
	end

endmodule

/* design/ex_stage.sv */
//****************************************
// RV64I execute stage, one instruction per cycle, one cycle latency.
// no back-pressure: in_valid is a single-cycle strobe per instruction.
// memory enables and except are cleared on cycles without in_valid.
//****************************************

`timescale 1ns/10ps

module ex_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic [ex_pkg::ilen-1:0] instr,
	input  logic [ex_pkg::xlen-1:0] pc,
	input  logic [ex_pkg::xlen-1:0] rs1_data,
	input  logic [ex_pkg::xlen-1:0] rs2_data,
	output logic                    out_valid,
	output ex_pkg::ex_out_t         out
);

	import ex_pkg::*;

	ex_ctrl_t        ctrl;
	logic [xlen-1:0] alu_result;
	mem_req_t        mem_req;
	except_e         except;
	ex_out_t         data_q;   // payload of the result bundle.
	logic            rd_en_q;
	logic            wr_en_q;
	except_e         except_q;

	ex_ctrl u_ctrl (.instr(instr), .ctrl(ctrl));

	ex_alu u_alu (
		.ctrl     (ctrl),
		.pc       (pc),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.result   (alu_result)
	);

	ex_mem_access u_mem (
		.ctrl     (ctrl),
		.addr     (alu_result),
		.rs2_data (rs2_data),
		.req      (mem_req),
		.except   (except)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			rd_en_q   <= 1'b0;
			wr_en_q   <= 1'b0;
			except_q  <= exc_none;
		end else begin
			out_valid <= in_valid;
			rd_en_q   <= in_valid & mem_req.rd_en;
			wr_en_q   <= in_valid & mem_req.wr_en;
			except_q  <= in_valid ? except : exc_none;
		end
	end

	always_ff @(posedge clk) begin
		data_q <= '{result: alu_result, mem: mem_req, except: except};
	end

	// enables and cause come from the reset-cleared registers.
	always_comb begin
		out           = data_q;
		out.mem.rd_en = rd_en_q;
		out.mem.wr_en = wr_en_q;
		out.except    = except_q;
	end

endmodule

/* bench/tb_ex_stage.sv */
//****************************************
// vectors come from bench/ex_testdata.txt, relative to the project root.
// the file holds a hex count, then twelve hex fields per vector.
// result and request payload are not checked on idle vectors,
// and the result is not checked on illegal instructions.
//****************************************

`timescale 1ns/10ps

module tb_ex_stage;

	import ex_pkg::*;

	localparam int max_vec   = 40;
	localparam int vec_words = 12;

	// field positions inside one vector.
	localparam int f_valid  = 0;
	localparam int f_instr  = 1;
	localparam int f_pc     = 2;
	localparam int f_rs1    = 3;
	localparam int f_rs2    = 4;
	localparam int f_result = 5;
	localparam int f_rd     = 6;
	localparam int f_wr     = 7;
	localparam int f_addr   = 8;
	localparam int f_wdata  = 9;
	localparam int f_strb   = 10;
	localparam int f_exc    = 11;

	logic            clk;
	logic            rst_n;
	logic            in_valid;
	logic [ilen-1:0] instr;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic            out_valid;
	ex_out_t         out;

	logic [63:0] vec_mem [0:max_vec*vec_words];
	int          vec_count;
	int          cycle_count = 0;
	int          cycle_limit = 1000;
	int          pending [$]; // vector indices waiting for their result.

	ex_stage uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.instr     (instr),
		.pc        (pc),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.out_valid (out_valid),
		.out       (out)
	);

	always #5 clk = ~clk;

	function automatic logic [63:0] vec_field(input int idx, input int pos);
		return vec_mem[1 + idx*vec_words + pos];
	endfunction

	task automatic check_val(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "stopped at the first wrong value");
		end
	endtask

	task automatic drive_vec(input int idx);
		in_valid = vec_field(idx, f_valid) != 0;
		instr    = ilen'(vec_field(idx, f_instr));
		pc       = vec_field(idx, f_pc);
		rs1_data = vec_field(idx, f_rs1);
		rs2_data = vec_field(idx, f_rs2);
	endtask

	task automatic drive_idle();
		in_valid = 1'b0;
		instr    = '0;
		pc       = '0;
		rs1_data = '0;
		rs2_data = '0;
	endtask

	task automatic check_reset();
		check_val("out_valid in reset", 64'(out_valid), 64'd0);
		check_val("rd_en in reset", 64'(out.mem.rd_en), 64'd0);
		check_val("wr_en in reset", 64'(out.mem.wr_en), 64'd0);
		check_val("except in reset", 64'(out.except), 64'(exc_none));
	endtask

	task automatic check_result(input int idx);
		string tag;
		tag = $sformatf("vector %0d", idx);
		check_val({tag, " out_valid"}, 64'(out_valid), vec_field(idx, f_valid));
		check_val({tag, " rd_en"}, 64'(out.mem.rd_en), vec_field(idx, f_rd));
		check_val({tag, " wr_en"}, 64'(out.mem.wr_en), vec_field(idx, f_wr));
		if (vec_field(idx, f_valid) != 0) begin
			check_val({tag, " except"}, 64'(out.except), vec_field(idx, f_exc));
			// an illegal instruction leaves the result undefined.
			if (vec_field(idx, f_exc) != 64'(exc_illegal))
				check_val({tag, " result"}, out.result, vec_field(idx, f_result));
			check_val({tag, " addr"}, out.mem.addr, vec_field(idx, f_addr));
			check_val({tag, " wr_data"}, out.mem.wr_data, vec_field(idx, f_wdata));
			check_val({tag, " wr_strb"}, 64'(out.mem.wr_strb), vec_field(idx, f_strb));
		end
	endtask

	// guards against a stalled run.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run took more than %0d cycles", cycle_limit);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		drive_idle();
		$readmemh("bench/ex_testdata.txt", vec_mem);
		vec_count = int'(vec_mem[0]);
		if (vec_count < 1 || vec_count > max_vec) begin
			$display("vector file is missing or holds a bad count (%0d)", vec_count);
			$display("sim failed");
			$fatal(1, "no usable vectors");
		end
		cycle_limit = vec_count + 20; // reset and drain fit in the margin.

		repeat (4) @(posedge clk);
		@(negedge clk);
		check_reset();
		rst_n = 1'b1;

		// one vector per cycle, the last pass only drains the final result.
		for (int i = 0; i <= vec_count; i++) begin
			// the vector driven one falling edge ago is on the outputs now.
			if (pending.size() > 0)
				check_result(pending.pop_front());
			if (i < vec_count) begin
				drive_vec(i);
				pending.push_back(i);
			end else begin
				drive_idle();
			end
			@(negedge clk);
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* bench/ex_testdata.txt */
// columns: in_valid instr pc rs1 rs2 result rd_en wr_en addr wr_data wr_strb except
// all values hex; except 0 none, 1 misaligned, 2 illegal
// first value is the vector count (hex 28 = 40)
28
1 00c58533 80000000 100000005 ffffffff 200000004 0 0 0 0 0 0
1 40c58533 80000000 5 7 fffffffffffffffe 0 0 0 0 0 0
1 00c5a533 80000000 ffffffffffffffff 1 1 0 0 0 0 0 0
1 00c5b533 80000000 ffffffffffffffff 1 0 0 0 0 0 0 0
1 00c5a533 80000000 1 8000000000000000 0 0 0 0 0 0 0
1 00c5c533 80000000 ff00ff00ff00ff00 0ff00ff00ff00ff0 f0f0f0f0f0f0f0f0 0 0 0 0 0 0
1 00c5e533 80000000 ff00ff00ff00ff00 0ff00ff00ff00ff0 fff0fff0fff0fff0 0 0 0 0 0 0
1 00c5f533 80000000 ff00ff00ff00ff00 0ff00ff00ff00ff0 0f000f000f000f00 0 0 0 0 0 0
1 fff58513 80000000 0 0 ffffffffffffffff 0 0 0 0 0 0
1 fff5a513 80000000 fffffffffffffffe 0 1 0 0 0 0 0 0
1 fff5b513 80000000 5 0 1 0 0 0 0 0 0
1 7ff5c513 80000000 ff 0 700 0 0 0 0 0 0
1 8005e513 80000000 123 0 fffffffffffff923 0 0 0 0 0 0
1 0f05f513 80000000 12345678 0 70 0 0 0 0 0 0
1 00c59533 80000000 1 3f 8000000000000000 0 0 0 0 0 0
1 00c5d533 80000000 8000000000000000 28 800000 0 0 0 0 0 0
1 40c5d533 80000000 8000000000000000 28 ffffffffff800000 0 0 0 0 0 0
1 02159513 80000000 3 0 600000000 0 0 0 0 0 0
1 4245d513 80000000 f000000000000000 0 ffffffffff000000 0 0 0 0 0 0
1 0045d513 80000000 f000000000000000 0 0f00000000000000 0 0 0 0 0 0
1 00c5853b 80000000 7fffffff 1 ffffffff80000000 0 0 0 0 0 0
1 40c5853b 80000000 100000000 1 ffffffffffffffff 0 0 0 0 0 0
1 00c5953b 80000000 1 3f ffffffff80000000 0 0 0 0 0 0
1 00c5d53b 80000000 ffffffff80000000 4 8000000 0 0 0 0 0 0
1 40c5d53b 80000000 ffffffff80000000 4 fffffffff8000000 0 0 0 0 0 0
1 0105851b 80000000 fffffff0 0 0 0 0 0 0 0 0
1 4085d51b 80000000 80000000 0 ffffffffff800000 0 0 0 0 0 0
1 80000537 80000000 1234 0 ffffffff80000000 0 0 0 0 0 0
1 12345517 400000 0 0 12745000 0 0 0 0 0 0
1 00000073 80000000 deadbeefcafef00d 0 deadbeefcafef00d 0 0 0 0 0 0
1 00c58823 80000000 1000 1122334455667788 1010 0 1 1010 88 1 0
1 00c59c23 80000000 1000 1122334455667788 1018 0 1 1018 7788 3 0
1 fec5ac23 80000000 1000 1122334455667788 ff8 0 1 ff8 55667788 f 0
1 00c5b023 80000000 1000 1122334455667788 1000 0 1 1000 1122334455667788 ff 0
0 00c5b023 80000000 1000 1122334455667788 0 0 0 0 0 0 0
1 0205b503 80000000 2000 0 2020 1 0 2020 0 0 0
1 0005a503 80000000 3008 0 3008 1 0 3008 0 0 0
1 0045a503 80000000 3000 0 3004 1 0 3004 0 0 1
1 00c59123 80000000 1000 1122334455667788 1002 0 1 1002 7788 3 1
1 0000006f 80000000 0 0 0 0 0 0 0 0 2

/* project.f */
common/ex_pkg.sv
design/ex_ctrl.sv
alu/ex_alu.sv
design/ex_mem_access.sv
design/ex_stage.sv
bench/tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f project.f \
	--top-module tb_ex_stage \
	-o sim_ex_stage

sim_rc=0
sim_out=$(./obj_dir/sim_ex_stage 2>&1) || sim_rc=$?
echo "$sim_out"

if grep -q "^sim passed$" <<< "$sim_out"; then
	exit 0
fi
echo "run_sim: simulation failed (exit status $sim_rc)"
exit 1
